/* all.f */
hdl/color_pkg.sv
hdl/scene_pkg.sv
hdl/ship_layer.sv
hdl/weapon_layer.sv
hdl/pixel_compositor.sv
hdl/color_mapper.sv
testbench/color_mapper_props.sv
testbench/tb_color_mapper.sv

/* hdl/color_mapper.sv */
`timescale 1ns/10ps

module color_mapper
    import color_pkg::*, scene_pkg::*;
#(
    parameter int n_torpedo = 4,
    parameter int n_bullet  = 10
) (
    input  logic       Clk,
    input  logic       rst_n,
    input  logic       hp_hit,
    input  pal_idx_t   bg_idx,
    input  sprite_px_t ship1,
    input  sprite_px_t ship2,
    input  hull_t      hull1,
    input  hull_t      hull2,
    input  sprite_px_t torp1   [n_torpedo],
    input  sprite_px_t torp2   [n_torpedo],
    input  sprite_px_t bullet1 [n_bullet],
    input  sprite_px_t bullet2 [n_bullet],
    output logic [7:0] vga_r,
    output logic [7:0] vga_g,
    output logic [7:0] vga_b
);

    layer_px_t ship_px;
    layer_px_t weapon_px;

    // ------------------------------
    // Sprite layers
    // ------------------------------

    ship_layer u_ship_layer (
        .ship1   (ship1),
        .ship2   (ship2),
        .hull1   (hull1),
        .hull2   (hull2),
        .ship_px (ship_px)
    );

    weapon_layer #(
        .n_torpedo (n_torpedo),
        .n_bullet  (n_bullet)
    ) u_weapon_layer (
        .torp1     (torp1),
        .torp2     (torp2),
        .bullet1   (bullet1),
        .bullet2   (bullet2),
        .weapon_px (weapon_px)
    );

    // Background, priority and output register
    pixel_compositor u_pixel_compositor (
        .Clk       (Clk),
        .rst_n     (rst_n),
        .hp_hit    (hp_hit),
        .bg_idx    (bg_idx),
        .ship_px   (ship_px),
        .weapon_px (weapon_px),
        .vga_r     (vga_r),
        .vga_g     (vga_g),
        .vga_b     (vga_b)
    );

endmodule

/* hdl/color_pkg.sv */
package color_pkg;

    // ------------------------------
    // Basic color types
    // ------------------------------

    typedef struct packed {
        logic [7:0] red;
        logic [7:0] green;
        logic [7:0] blue;
    } color_t;

    typedef logic [3:0] pal_idx_t;

    // Entry 0 is the leftmost value of each table
    typedef color_t [0:15] palette_t;

    // ------------------------------
    // Palettes
    // ------------------------------

    // Sea and sky tones of the playfield
    localparam palette_t bg_palette = '{
        24'h0f4792, 24'h3577cd, 24'h4fc3fc, 24'h4586d9,
        24'h033477, 24'h4176bb, 24'h4faafb, 24'h043578,
        24'h4b93ed, 24'hfff78f, 24'h505050, 24'h535c74,
        24'hdfc5ae, 24'h9ea7af, 24'h000000, 24'hffffff
    };

    // Three hull styles, grey marks the cut-out around the hull
    localparam palette_t hull_a_palette = '{
        24'h808080, 24'hf3f1f3, 24'h201c18, 24'hfffbef,
        24'h3b3b3b, 24'h54657b, 24'haa3e49, 24'h767778,
        24'hbe3647, 24'hfff78f, 24'h505050, 24'h535c74,
        24'hdfc5ae, 24'h9ea7af, 24'h000000, 24'hffffff
    };

    localparam palette_t hull_b_palette = '{
        24'hf9f1e9, 24'hc25f4f, 24'h686554, 24'hd7c1b2,
        24'h455273, 24'hffd1c0, 24'hf19a3e, 24'h362e3e,
        24'h8594a5, 24'hf4f0e8, 24'h505050, 24'h535c74,
        24'h808080, 24'h9ea7af, 24'h000000, 24'hffffff
    };

    localparam palette_t hull_c_palette = '{
        24'h695871, 24'h808080, 24'hefe7e7, 24'h694a82,
        24'h4d5ea2, 24'ha5a3a2, 24'hfed9d2, 24'h9e7d64,
        24'h474757, 24'h6f4d90, 24'h544058, 24'h322a4c,
        24'heee7e7, 24'h9ea7af, 24'h000000, 24'hffffff
    };

    // Shared by torpedoes and bullets of both players
    localparam palette_t weapon_palette = '{
        24'h808080, 24'hffffff, 24'h3c3c3e, 24'h686a70,
        24'he27a55, 24'hffd778, 24'hba160d, 24'hffffe1,
        24'hca2d27, 24'he9a16c, 24'h505050, 24'h535c74,
        24'hdfc5ae, 24'h9ea7af, 24'h000000, 24'hfb2901
    };

    // ------------------------------
    // Special colors
    // ------------------------------

    // Transparent keys
    localparam color_t ship_key   = 24'h808080;
    localparam color_t weapon_key = 24'hffffff;

    // Health bar paint
    localparam color_t hp_color = 24'hff0000;

endpackage

/* hdl/pixel_compositor.sv */
`timescale 1ns/10ps

module pixel_compositor
    import color_pkg::*, scene_pkg::*;
(
    input  logic       Clk,
    input  logic       rst_n,
    input  logic       hp_hit,
    input  pal_idx_t   bg_idx,
    input  layer_px_t  ship_px,
    input  layer_px_t  weapon_px,
    output logic [7:0] vga_r,
    output logic [7:0] vga_g,
    output logic [7:0] vga_b
);

    color_t bg_color;
    color_t next_color;
    color_t color_q;

    assign bg_color = bg_palette[bg_idx];

    // ------------------------------
    // Layer priority
    // ------------------------------

    always_comb begin
        if (hp_hit) begin
            next_color = hp_color;
        end
        else if (ship_px.hit) begin
            // Hides weapons even where the hull is cut out
            next_color = ship_px.see_through ? bg_color : ship_px.color;
        end
        else if (weapon_px.hit) begin
            next_color = weapon_px.see_through ? bg_color : weapon_px.color;
        end
        else begin
            next_color = bg_color;
        end
    end

    // ------------------------------
    // Output stage
    // ------------------------------

    always_ff @(posedge Clk or negedge rst_n) begin
        if (!rst_n) begin
            color_q <= '0;
        end
        else begin
            color_q <= next_color;
        end
    end

    assign vga_r = color_q.red;
    assign vga_g = color_q.green;
    assign vga_b = color_q.blue;

endmodule

/* hdl/scene_pkg.sv */
package scene_pkg;

    import color_pkg::*;

    // ------------------------------
    // Sprite inputs
    // ------------------------------

    // One sprite's view of the current pixel
    typedef struct packed {
        logic     hit;
        pal_idx_t idx;
    } sprite_px_t;

    // Hull style picked by a player; code 3 is treated as hull_a
    typedef enum logic [1:0] {
        hull_a = 2'd0,
        hull_b = 2'd1,
        hull_c = 2'd2
    } hull_t;

    // ------------------------------
    // Layer outputs
    // ------------------------------

    // see_through only matters when hit is set
    typedef struct packed {
        logic   hit;
        logic   see_through;
        color_t color;
    } layer_px_t;

endpackage

/* hdl/ship_layer.sv */
`timescale 1ns/10ps

module ship_layer
    import color_pkg::*, scene_pkg::*;
(
    input  sprite_px_t ship1,
    input  sprite_px_t ship2,
    input  hull_t      hull1,
    input  hull_t      hull2,
    output layer_px_t  ship_px
);

    color_t color1;
    color_t color2;
    logic   opaque1;
    logic   opaque2;

    // Palette of the chosen hull, unknown codes use hull_a
    function automatic color_t hull_lookup(input hull_t hull, input pal_idx_t idx);
        case (hull)
            hull_b:  return hull_b_palette[idx];
            hull_c:  return hull_c_palette[idx];
            default: return hull_a_palette[idx];
        endcase
    endfunction

    // ------------------------------
    // Per-player lookup
    // ------------------------------

    assign color1 = hull_lookup(hull1, ship1.idx);
    assign color2 = hull_lookup(hull2, ship2.idx);

    assign opaque1 = ship1.hit && (color1 != ship_key);
    assign opaque2 = ship2.hit && (color2 != ship_key);

    // ------------------------------
    // Player 1 on top
    // ------------------------------

    always_comb begin
        ship_px.hit         = ship1.hit | ship2.hit;
        ship_px.see_through = 1'b0;
        ship_px.color       = color1;
        if (opaque1) begin
            ship_px.color = color1;
        end
        else if (opaque2) begin
            // Player 2 shows through the grey cut-out of player 1
            ship_px.color = color2;
        end
        else begin
            ship_px.see_through = 1'b1;
        end
    end

endmodule

/* hdl/weapon_layer.sv */
`timescale 1ns/10ps

module weapon_layer
    import color_pkg::*, scene_pkg::*;
#(
    parameter int n_torpedo = 4,
    parameter int n_bullet  = 10
) (
    input  sprite_px_t torp1   [n_torpedo],
    input  sprite_px_t torp2   [n_torpedo],
    input  sprite_px_t bullet1 [n_bullet],
    input  sprite_px_t bullet2 [n_bullet],
    output layer_px_t  weapon_px
);

    localparam int n_group = 4;
    localparam int n_slot  = 2 * n_torpedo + 2 * n_bullet;

    // Group order: p1 torpedoes, p2 torpedoes, p2 bullets, p1 bullets
    localparam int group_lo [n_group] = '{
        0,
        n_torpedo,
        2 * n_torpedo,
        2 * n_torpedo + n_bullet
    };
    localparam int group_len [n_group] = '{n_torpedo, n_torpedo, n_bullet, n_bullet};

    sprite_px_t slot      [n_slot];
    logic       group_hit [n_group];
    pal_idx_t   group_idx [n_group];
    logic       found;
    pal_idx_t   win_idx;
    color_t     win_color;

    // ------------------------------
    // Slots in group order
    // ------------------------------

    always_comb begin
        for (int i = 0; i < n_torpedo; i++) begin
            slot[group_lo[0] + i] = torp1[i];
            slot[group_lo[1] + i] = torp2[i];
        end
        for (int i = 0; i < n_bullet; i++) begin
            slot[group_lo[2] + i] = bullet2[i];
            slot[group_lo[3] + i] = bullet1[i];
        end
    end

    // Lowest hitting slot inside each group
    always_comb begin
        for (int g = 0; g < n_group; g++) begin
            group_hit[g] = 1'b0;
            group_idx[g] = '0;
            // Walk downwards so the lowest index is written last
            for (int i = group_len[g] - 1; i >= 0; i--) begin
                if (slot[group_lo[g] + i].hit) begin
                    group_hit[g] = 1'b1;
                    group_idx[g] = slot[group_lo[g] + i].idx;
                end
            end
        end
    end

    // ------------------------------
    // First group with any hit
    // ------------------------------

    always_comb begin
        found   = 1'b0;
        win_idx = '0;
        for (int g = 0; g < n_group; g++) begin
            if (group_hit[g] && !found) begin
                found   = 1'b1;
                win_idx = group_idx[g];
            end
        end
    end

    assign win_color = weapon_palette[win_idx];

    // A white winner hides nothing, no later slot is tried
    assign weapon_px.hit         = found;
    assign weapon_px.see_through = (win_color == weapon_key);
    assign weapon_px.color       = win_color;

endmodule

/* testbench/color_mapper_props.sv */
`timescale 1ns/10ps

module color_mapper_props
    import color_pkg::*;
(
    input logic       Clk,
    input logic       rst_n,
    input logic       hp_hit,
    input logic [7:0] vga_r,
    input logic [7:0] vga_g,
    input logic [7:0] vga_b
);

    color_t vga_color;
    int     fail_count = 0;

    assign vga_color = {vga_r, vga_g, vga_b};

    // ------------------------------
    // Reset and override
    // ------------------------------

    // Sampled between rising edges where the register is stable
    a_reset_clears: assert property (@(negedge Clk) !rst_n |-> (vga_color == '0))
        else begin
            $error("VGA color not cleared while rst_n is low");
            fail_count++;
        end

    // Health bar paints the next pixel red
    a_hp_red: assert property (@(posedge Clk) disable iff (!rst_n)
        hp_hit |=> (vga_color == hp_color))
        else begin
            $error("hp_hit did not give pure red one cycle later");
            fail_count++;
        end

    a_known: assert property (@(posedge Clk) disable iff (!rst_n) !$isunknown(vga_color))
        else begin
            $error("VGA color unknown after reset");
            fail_count++;
        end

endmodule

bind color_mapper color_mapper_props u_props (
    .Clk    (Clk),
    .rst_n  (rst_n),
    .hp_hit (hp_hit),
    .vga_r  (vga_r),
    .vga_g  (vga_g),
    .vga_b  (vga_b)
);

/* testbench/tb_color_mapper.sv */
`timescale 1ns/10ps

module tb_color_mapper
    import color_pkg::*, scene_pkg::*;
();

    localparam int n_torpedo   = 4;
    localparam int n_bullet    = 10;
    localparam int n_random    = 4000;
    localparam int cycle_limit = 10000;

    logic        Clk;
    logic        rst_n;
    logic        hp_hit;
    pal_idx_t    bg_idx;
    sprite_px_t  ship1;
    sprite_px_t  ship2;
    hull_t       hull1;
    hull_t       hull2;
    sprite_px_t  torp1   [n_torpedo];
    sprite_px_t  torp2   [n_torpedo];
    sprite_px_t  bullet1 [n_bullet];
    sprite_px_t  bullet2 [n_bullet];
    logic [7:0]  vga_r;
    logic [7:0]  vga_g;
    logic [7:0]  vga_b;
    logic [15:0] lfsr_state;
    int          pixel_seq;
    int          checked_seq;

    color_mapper u_dut (
        .Clk     (Clk),
        .rst_n   (rst_n),
        .hp_hit  (hp_hit),
        .bg_idx  (bg_idx),
        .ship1   (ship1),
        .ship2   (ship2),
        .hull1   (hull1),
        .hull2   (hull2),
        .torp1   (torp1),
        .torp2   (torp2),
        .bullet1 (bullet1),
        .bullet2 (bullet2),
        .vga_r   (vga_r),
        .vga_g   (vga_g),
        .vga_b   (vga_b)
    );

    always #2 Clk = ~Clk;

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    // ------------------------------
    // LFSR stimulus
    // ------------------------------

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic logic [15:0] take_bits(input int n);
        logic [15:0] bits;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            bits       = {bits[14:0], lfsr_state[15]};
            lfsr_state = lfsr_next(lfsr_state);
        end
        return bits;
    endfunction

    // Set only when all n bits are ones
    function automatic logic rare_hit(input int n);
        logic [15:0] bits;
        bits = take_bits(n);
        return bits == 16'((1 << n) - 1);
    endfunction

    function automatic sprite_px_t random_sprite(input int n);
        sprite_px_t s;
        s.hit = rare_hit(n);
        s.idx = 4'(take_bits(4));
        return s;
    endfunction

    function automatic sprite_px_t hit_at(input pal_idx_t idx);
        sprite_px_t s;
        s.hit = 1'b1;
        s.idx = idx;
        return s;
    endfunction

    // ------------------------------
    // Reference model
    // ------------------------------

    function automatic color_t hull_color(input logic [1:0] code, input pal_idx_t idx);
        case (code)
            2'd1:    return hull_b_palette[idx];
            2'd2:    return hull_c_palette[idx];
            default: return hull_a_palette[idx];
        endcase
    endfunction

    function automatic color_t ref_color();
        color_t     bg;
        color_t     c1;
        color_t     c2;
        sprite_px_t slots [$];
        bg = bg_palette[bg_idx];
        c1 = hull_color(hull1, ship1.idx);
        c2 = hull_color(hull2, ship2.idx);
        if (hp_hit) return hp_color;
        if (ship1.hit || ship2.hit) begin
            if (ship1.hit && c1 != ship_key) return c1;
            if (ship2.hit && c2 != ship_key) return c2;
            return bg;
        end
        // Torpedoes of p1 and p2, then bullets of p2 and p1
        foreach (torp1[i]) slots.push_back(torp1[i]);
        foreach (torp2[i]) slots.push_back(torp2[i]);
        foreach (bullet2[i]) slots.push_back(bullet2[i]);
        foreach (bullet1[i]) slots.push_back(bullet1[i]);
        foreach (slots[i]) begin
            if (slots[i].hit) begin
                if (weapon_palette[slots[i].idx] == weapon_key) return bg;
                return weapon_palette[slots[i].idx];
            end
        end
        return bg;
    endfunction

    // ------------------------------
    // Driving and checking
    // ------------------------------

    task automatic clear_inputs(input pal_idx_t bg);
        hp_hit = 1'b0;
        bg_idx = bg;
        ship1  = '0;
        ship2  = '0;
        hull1  = hull_a;
        hull2  = hull_a;
        foreach (torp1[i]) torp1[i] = '0;
        foreach (torp2[i]) torp2[i] = '0;
        foreach (bullet1[i]) bullet1[i] = '0;
        foreach (bullet2[i]) bullet2[i] = '0;
    endtask

    task automatic start_pixel(input pal_idx_t bg);
        @(negedge Clk);
        clear_inputs(bg);
        pixel_seq++;
    endtask

    task automatic fill_random();
        hp_hit = rare_hit(4);
        bg_idx = 4'(take_bits(4));
        ship1  = random_sprite(3);
        ship2  = random_sprite(3);
        hull1  = hull_t'(2'(take_bits(2)));
        hull2  = hull_t'(2'(take_bits(2)));
        foreach (torp1[i]) torp1[i] = random_sprite(3);
        foreach (torp2[i]) torp2[i] = random_sprite(3);
        foreach (bullet1[i]) bullet1[i] = random_sprite(4);
        foreach (bullet2[i]) bullet2[i] = random_sprite(4);
    endtask

    task automatic check_channel(input string name, input logic [7:0] expected,
                                 input logic [7:0] actual);
        assert (actual === expected)
            else report_failure($sformatf("Error at %0t: %s expected %02h, got %02h",
                                          $time, name, expected, actual));
    endtask

    // Prediction taken at the rising edge and compared at the falling edge
    initial begin : compare_outputs
        color_t expected;
        int     seq;
        forever begin
            @(posedge Clk);
            seq      = rst_n ? pixel_seq : -1;
            expected = rst_n ? ref_color() : color_t'('0);
            @(negedge Clk);
            check_channel("vga_r", expected.red, vga_r);
            check_channel("vga_g", expected.green, vga_g);
            check_channel("vga_b", expected.blue, vga_b);
            assert (u_dut.u_props.fail_count == 0)
                else report_failure("A bound assertion on the VGA outputs failed");
            if (seq >= 0) checked_seq = seq;
        end
    end

    initial begin : watchdog
        for (int cycles = 0; cycles < cycle_limit; cycles++) begin
            @(negedge Clk);
        end
        report_failure("Simulation ran past its cycle limit");
    end

    // ------------------------------
    // Test sequence
    // ------------------------------

    initial begin : run_test
        int   waited;
        logic drained;
        Clk         = 1'b0;
        rst_n       = 1'b0;
        lfsr_state  = 16'd22705;
        pixel_seq   = 0;
        checked_seq = -1;
        // Black background keeps the first pixel after reset at zero
        clear_inputs(4'd14);
        repeat (4) @(negedge Clk);
        rst_n = 1'b1;

        waited = 0;
        while ($isunknown({vga_r, vga_g, vga_b}) || waited == 0) begin
            @(negedge Clk);
            waited++;
            if (waited > 8) report_failure("VGA outputs stayed unknown after reset");
        end

        for (int i = 0; i < 16; i++) begin
            start_pixel(4'(i));
        end

        // Hull styles where code 3 reads hull_a
        for (int code = 0; code < 4; code++) begin
            start_pixel(4'd2);
            ship1 = hit_at(4'd5);
            hull1 = hull_t'(2'(code));
            start_pixel(4'd3);
            ship2 = hit_at(4'd9);
            hull2 = hull_t'(2'(code));
        end
        start_pixel(4'd4);
        ship1 = hit_at(4'd0);
        ship2 = hit_at(4'd1);
        hull2 = hull_b;
        start_pixel(4'd6);
        ship1 = hit_at(4'd1);
        hull1 = hull_c;
        ship2 = hit_at(4'd12);
        hull2 = hull_b;
        start_pixel(4'd8);
        ship1 = hit_at(4'd0);
        start_pixel(4'd1);
        ship2    = hit_at(4'd3);
        torp1[0] = hit_at(4'd4);
        // Cut-out hull still hides the bullet
        start_pixel(4'd10);
        ship1      = hit_at(4'd0);
        bullet1[2] = hit_at(4'd6);

        // Weapon group order and lowest slot
        start_pixel(4'd0);
        torp2[3]   = hit_at(4'd4);
        bullet1[0] = hit_at(4'd5);
        start_pixel(4'd0);
        bullet2[7] = hit_at(4'd8);
        bullet2[5] = hit_at(4'd6);
        bullet1[0] = hit_at(4'd9);
        start_pixel(4'd0);
        torp1[2] = hit_at(4'd3);
        torp1[1] = hit_at(4'd2);
        torp2[0] = hit_at(4'd15);
        start_pixel(4'd0);
        bullet1[9] = hit_at(4'd7);
        bullet1[4] = hit_at(4'd15);
        start_pixel(4'd11);
        torp1[0] = hit_at(4'd1);
        torp1[1] = hit_at(4'd6);
        start_pixel(4'd11);
        torp2[0]   = hit_at(4'd1);
        bullet2[0] = hit_at(4'd6);

        repeat (16) begin
            start_pixel(4'd0);
            fill_random();
            hp_hit = 1'b1;
        end

        repeat (n_random) begin
            start_pixel(4'd0);
            fill_random();
        end

        drained = 1'b0;
        for (int i = 0; i < 8 && !drained; i++) begin
            @(negedge Clk);
            drained = (checked_seq == pixel_seq);
        end
        if (!drained) begin
            report_failure("Last pixel was never compared");
        end
        else if (u_dut.u_props.fail_count != 0) begin
            report_failure("A bound assertion on the VGA outputs failed");
        end
        else begin
            $display("TEST OK");
            $finish;
        end
    end

endmodule
